// ==== design/soc_pkg.sv ====
package soc_pkg;

  // Bus operation
  typedef enum logic {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } bus_op_e;

  typedef struct packed {
    bus_op_e     op;
    logic [31:0] addr;
    logic [31:0] wdata;
  } bus_req_t;

  typedef struct packed {
    logic        err;
    logic [31:0] rdata;
  } bus_rsp_t;

  // Return stack events, one per cycle
  typedef enum logic [1:0] {
    RAS_NONE = 2'd0,
    RAS_CALL = 2'd1,
    RAS_RET  = 2'd2
  } ras_op_e;

  typedef struct packed {
    ras_op_e     op;
    logic [31:0] addr;
  } ras_evt_t;

  typedef struct packed {
    logic [15:0] mismatch_count;
    logic [7:0]  occupancy;
    logic [5:0]  reserved;
    logic        full;
    logic        empty;
  } ras_status_t;

  // Register map
  localparam logic [31:0] RAM_BASE      = 32'h0000_0000;
  localparam logic [31:0] DISP_ADDR     = 32'h0000_1000;
  localparam logic [31:0] CNT_ADDR      = 32'h0000_1004;
  localparam logic [31:0] RAS_STAT_ADDR = 32'h0000_1008;
  localparam logic [31:0] RAS_TOP_ADDR  = 32'h0000_100C;

endpackage

// ==== design/mem_controller.sv ====
module mem_controller
  import soc_pkg::*;
#(
  parameter int unsigned RAM_WORDS = 256
) (
  input  logic        clk,
  input  logic        arst_n,
  input  logic        req_valid,
  output logic        req_ready,
  input  bus_req_t    req,
  output logic        rsp_valid,
  input  logic        rsp_ready,
  output bus_rsp_t    rsp,
  input  ras_status_t ras_status,
  input  logic [31:0] ras_top,
  output logic        clear_mismatch,
  output logic [31:0] disp_value
);

  localparam int unsigned AW = (RAM_WORDS > 1) ? $clog2(RAM_WORDS) : 1;
  localparam logic [31:0] RAM_BYTES = 32'(RAM_WORDS) * 32'd4;

  // Target of the current request
  typedef enum logic [2:0] {
    SEL_NONE,
    SEL_RAM,
    SEL_DISP,
    SEL_CNT,
    SEL_STAT,
    SEL_TOP
  } sel_e;

  logic [31:0] ram [RAM_WORDS];

  logic          ready_q;
  logic          accept;
  logic          wr;
  sel_e          sel;
  logic [31:0]   ram_off;
  logic [AW-1:0] ram_idx;
  logic [31:0]   rd_data;
  bus_rsp_t      rsp_nxt;
  logic [31:0]   disp_q;
  logic [31:0]   cnt_q;

  // Held low through reset, then open from the first cycle
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ready_q <= 1'b0;
    end else begin
      ready_q <= 1'b1;
    end
  end

  assign req_ready = ready_q && (!rsp_valid || rsp_ready);
  assign accept    = req_valid && req_ready;
  assign wr        = accept && (req.op == OP_WRITE);

  assign ram_off = req.addr - RAM_BASE;
  assign ram_idx = ram_off[AW+1:2];

  // Address decode
  always_comb begin
    if (ram_off < RAM_BYTES) begin
      sel = SEL_RAM;
    end else if (req.addr == DISP_ADDR) begin
      sel = SEL_DISP;
    end else if (req.addr == CNT_ADDR) begin
      sel = SEL_CNT;
    end else if (req.addr == RAS_STAT_ADDR) begin
      sel = SEL_STAT;
    end else if (req.addr == RAS_TOP_ADDR) begin
      sel = SEL_TOP;
    end else begin
      sel = SEL_NONE;
    end
  end

  always_comb begin
    case (sel)
      SEL_RAM:  rd_data = ram[ram_idx];
      SEL_DISP: rd_data = disp_q;
      SEL_CNT:  rd_data = cnt_q;
      SEL_STAT: rd_data = ras_status;
      SEL_TOP:  rd_data = ras_top;
      default:  rd_data = '0;
    endcase
  end

  // Writes and errors return zero data
  always_comb begin
    rsp_nxt.err   = (sel == SEL_NONE);
    rsp_nxt.rdata = (req.op == OP_READ && sel != SEL_NONE) ? rd_data : '0;
  end

  always_ff @(posedge clk) begin
    if (wr && sel == SEL_RAM) begin
      ram[ram_idx] <= req.wdata;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      disp_q <= '0;
    end else if (wr && sel == SEL_DISP) begin
      disp_q <= req.wdata;
    end
  end

  // Free-running cycle counter
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      cnt_q <= '0;
    end else if (wr && sel == SEL_CNT) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_q + 32'd1;
    end
  end

  // One pending response, held until taken
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rsp_valid <= 1'b0;
    end else if (accept) begin
      rsp_valid <= 1'b1;
    end else if (rsp_ready) begin
      rsp_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      rsp <= rsp_nxt;
    end
  end

  assign clear_mismatch = wr && (sel == SEL_STAT);
  assign disp_value     = disp_q;

endmodule

// ==== design/return_stack.sv ====
module return_stack
  import soc_pkg::*;
#(
  parameter int unsigned RAS_DEPTH = 8
) (
  input  logic        clk,
  input  logic        arst_n,
  input  ras_evt_t    ras_evt,
  input  logic        clear_mismatch,
  output ras_status_t ras_status,
  output logic [31:0] ras_top
);

  localparam int unsigned PW = (RAS_DEPTH > 1) ? $clog2(RAS_DEPTH) : 1;
  localparam int unsigned OW = $clog2(RAS_DEPTH + 1);

  logic [31:0] stack_q [RAS_DEPTH];

  logic [PW-1:0] top_q;
  logic [PW-1:0] push_ptr;
  logic [OW-1:0] occ_q;
  logic [15:0]   mis_q;
  logic          full;
  logic          empty;
  logic          push;
  logic          pop;
  logic          miss;

  function automatic logic [PW-1:0] ptr_inc(input logic [PW-1:0] p);
    if (p == PW'(RAS_DEPTH - 1)) begin
      return '0;
    end
    return p + 1'b1;
  endfunction

  function automatic logic [PW-1:0] ptr_dec(input logic [PW-1:0] p);
    if (p == '0) begin
      return PW'(RAS_DEPTH - 1);
    end
    return p - 1'b1;
  endfunction

  assign full     = (occ_q == OW'(RAS_DEPTH));
  assign empty    = (occ_q == '0);
  assign push     = (ras_evt.op == RAS_CALL);
  assign pop      = (ras_evt.op == RAS_RET);
  assign push_ptr = ptr_inc(top_q);

  // Empty pop counts as a misprediction
  assign miss = pop && (empty || stack_q[top_q] != ras_evt.addr);

  // When full the next slot holds the oldest entry
  always_ff @(posedge clk) begin
    if (push) begin
      stack_q[push_ptr] <= ras_evt.addr;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      top_q <= '0;
      occ_q <= '0;
    end else if (push) begin
      top_q <= push_ptr;
      if (!full) begin
        occ_q <= occ_q + 1'b1;
      end
    end else if (pop && !empty) begin
      top_q <= ptr_dec(top_q);
      occ_q <= occ_q - 1'b1;
    end
  end

  // Clear wins over a same-cycle increment
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      mis_q <= '0;
    end else if (clear_mismatch) begin
      mis_q <= '0;
    end else if (miss && mis_q != 16'hFFFF) begin
      mis_q <= mis_q + 16'd1;
    end
  end

  always_comb begin
    ras_status.mismatch_count = mis_q;
    ras_status.occupancy      = 8'(occ_q);
    ras_status.reserved       = '0;
    ras_status.full           = full;
    ras_status.empty          = empty;
  end

  assign ras_top = empty ? '0 : stack_q[top_q];

endmodule

// ==== design/seg_display.sv ====
module seg_display #(
  parameter int unsigned SCAN_DIV = 1000
) (
  input  logic        clk,
  input  logic        arst_n,
  input  logic [31:0] disp_value,
  output logic [7:0]  an,
  output logic [6:0]  seg
);

  localparam int unsigned PW = (SCAN_DIV > 1) ? $clog2(SCAN_DIV) : 1;

  // Anode codes, one digit low at a time
  typedef enum logic [7:0] {
    DIG0 = 8'hFE,
    DIG1 = 8'hFD,
    DIG2 = 8'hFB,
    DIG3 = 8'hF7,
    DIG4 = 8'hEF,
    DIG5 = 8'hDF,
    DIG6 = 8'hBF,
    DIG7 = 8'h7F
  } digit_e;

  logic [PW-1:0] div_q;
  logic          tick;
  digit_e        dig_q;
  digit_e        dig_nxt;
  logic [2:0]    idx_nxt;

  function automatic digit_e next_digit(input digit_e d);
    case (d)
      DIG0:    return DIG1;
      DIG1:    return DIG2;
      DIG2:    return DIG3;
      DIG3:    return DIG4;
      DIG4:    return DIG5;
      DIG5:    return DIG6;
      DIG6:    return DIG7;
      default: return DIG0;
    endcase
  endfunction

  function automatic logic [2:0] digit_idx(input digit_e d);
    case (d)
      DIG1:    return 3'd1;
      DIG2:    return 3'd2;
      DIG3:    return 3'd3;
      DIG4:    return 3'd4;
      DIG5:    return 3'd5;
      DIG6:    return 3'd6;
      DIG7:    return 3'd7;
      default: return 3'd0;
    endcase
  endfunction

  // Active-low segments
  function automatic logic [6:0] hex_to_seg(input logic [3:0] h);
    case (h)
      4'h0:    return 7'b0000001;
      4'h1:    return 7'b1001111;
      4'h2:    return 7'b0010010;
      4'h3:    return 7'b0000110;
      4'h4:    return 7'b1001100;
      4'h5:    return 7'b0100100;
      4'h6:    return 7'b0100000;
      4'h7:    return 7'b0001111;
      4'h8:    return 7'b0000000;
      4'h9:    return 7'b0000100;
      4'hA:    return 7'b0001000;
      4'hB:    return 7'b1100000;
      4'hC:    return 7'b0110001;
      4'hD:    return 7'b1000010;
      4'hE:    return 7'b0110000;
      default: return 7'b0111000;
    endcase
  endfunction

  assign tick    = (div_q == PW'(SCAN_DIV - 1));
  assign dig_nxt = tick ? next_digit(dig_q) : dig_q;
  assign idx_nxt = digit_idx(dig_nxt);

  // Scan prescaler
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      div_q <= '0;
    end else if (tick) begin
      div_q <= '0;
    end else begin
      div_q <= div_q + 1'b1;
    end
  end

  // Anode and pattern move together
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      dig_q <= DIG0;
      seg   <= 7'b1111111;
    end else begin
      dig_q <= dig_nxt;
      seg   <= hex_to_seg(disp_value[{idx_nxt, 2'b00} +: 4]);
    end
  end

  assign an = dig_q;

endmodule

// ==== design/soc_top.sv ====
module soc_top
  import soc_pkg::*;
#(
  parameter int unsigned RAM_WORDS = 256,
  parameter int unsigned RAS_DEPTH = 8,
  parameter int unsigned SCAN_DIV  = 1000
) (
  input  logic     clk,
  input  logic     arst_n,
  input  logic     req_valid,
  output logic     req_ready,
  input  bus_req_t req,
  output logic     rsp_valid,
  input  logic     rsp_ready,
  output bus_rsp_t rsp,
  input  ras_evt_t ras_evt,
  output logic [7:0] an,
  output logic [6:0] seg
);

  ras_status_t ras_status;
  logic [31:0] ras_top;
  logic        clear_mismatch;
  logic [31:0] disp_value;

  mem_controller #(
    .RAM_WORDS(RAM_WORDS)
  ) mem_controller_i (
    .clk           (clk),
    .arst_n        (arst_n),
    .req_valid     (req_valid),
    .req_ready     (req_ready),
    .req           (req),
    .rsp_valid     (rsp_valid),
    .rsp_ready     (rsp_ready),
    .rsp           (rsp),
    .ras_status    (ras_status),
    .ras_top       (ras_top),
    .clear_mismatch(clear_mismatch),
    .disp_value    (disp_value)
  );

  return_stack #(
    .RAS_DEPTH(RAS_DEPTH)
  ) return_stack_i (
    .clk           (clk),
    .arst_n        (arst_n),
    .ras_evt       (ras_evt),
    .clear_mismatch(clear_mismatch),
    .ras_status    (ras_status),
    .ras_top       (ras_top)
  );

  seg_display #(
    .SCAN_DIV(SCAN_DIV)
  ) seg_display_i (
    .clk       (clk),
    .arst_n    (arst_n),
    .disp_value(disp_value),
    .an        (an),
    .seg       (seg)
  );

endmodule

// ==== test/tb_checker.sv ====
module tb_checker
  import soc_pkg::*;
(
  input  logic       clk,
  input  logic       arst_n,
  input  logic       req_valid,
  input  logic       req_ready,
  input  bus_req_t   req,
  input  logic       rsp_valid,
  input  logic       rsp_ready,
  input  bus_rsp_t   rsp,
  input  logic [7:0] an,
  input  logic [6:0] seg,
  input  bus_rsp_t   exp_rsp,
  input  logic       exp_cnt,
  input  int         test_num,
  output logic       idle,
  output int         err_count,
  output int         tests_run,
  output int         tests_failed
);

  timeunit 1ns;
  timeprecision 100ps;

  typedef struct packed {
    logic [31:0] addr;
    bus_rsp_t    rsp;
  } exp_t;

  // Hex digit patterns, active low, segment a in the top bit
  localparam logic [6:0] SEG_TABLE [16] = '{
    7'h01, 7'h4F, 7'h12, 7'h06, 7'h4C, 7'h24, 7'h20, 7'h0F,
    7'h00, 7'h04, 7'h08, 7'h60, 7'h31, 7'h42, 7'h30, 7'h38
  };

  exp_t        pending [$];
  logic [31:0] disp_mirror;
  logic [31:0] cnt_model;
  logic        rsp_due;
  int          skip;
  int          prev_test;
  int          test_errs;

  task automatic log_failure(input string msg);
    $display("%s", msg);
    err_count++;
    test_errs++;
  endtask

  task automatic check_response(input exp_t e);
    if (rsp !== e.rsp) begin
      log_failure($sformatf("Error at %0d ns: %08h gave err %0b data %08h, expected %0b %08h",
                            $time, e.addr, rsp.err, rsp.rdata, e.rsp.err, e.rsp.rdata));
    end
  endtask

  always @(posedge clk) begin
    int k;
    if (!arst_n) begin
      pending.delete();
      disp_mirror  = '0;
      cnt_model    = '0;
      rsp_due      = 1'b0;
      skip         = 3;
      prev_test    = 0;
      test_errs    = 0;
      err_count    = 0;
      tests_run    = 0;
      tests_failed = 0;
    end else begin
      if (test_num != prev_test) begin
        if (prev_test != 0) begin
          $display("Test %0d %s with %0d errors", prev_test,
                   (test_errs == 0) ? "passed" : "FAILED", test_errs);
          tests_run++;
          if (test_errs != 0) tests_failed++;
        end
        prev_test = test_num;
        test_errs = 0;
      end
      // Response one cycle after acceptance, no new request while one is held
      if (rsp_due && !rsp_valid) begin
        log_failure($sformatf("Error at %0d ns: no response one cycle after the request",
                              $time));
      end
      if (rsp_valid && !rsp_ready && req_ready) begin
        log_failure($sformatf("Error at %0d ns: request ready while a response is held",
                              $time));
      end
      if (rsp_valid && rsp_ready) begin
        if (pending.size() == 0) begin
          log_failure("A response arrived while no request was pending");
        end else begin
          check_response(pending.pop_front());
        end
      end
      // One digit lit per cycle, showing its nibble
      if (skip > 0) begin
        skip--;
      end else if ($countones(~an) != 1) begin
        log_failure($sformatf("Error at %0d ns: anode code %08b lights %0d digits",
                              $time, an, $countones(~an)));
      end else begin
        k = 0;
        for (int i = 0; i < 8; i++) begin
          if (!an[i]) k = i;
        end
        if (seg !== SEG_TABLE[disp_mirror[4*k +: 4]]) begin
          log_failure($sformatf("Error at %0d ns: digit %0d shows %07b, expected %07b",
                                $time, k, seg, SEG_TABLE[disp_mirror[4*k +: 4]]));
        end
      end
      rsp_due = req_valid && req_ready;
      if (req_valid && req_ready) begin
        if (exp_cnt) begin
          pending.push_back(exp_t'{addr: req.addr, rsp: bus_rsp_t'{1'b0, cnt_model}});
        end else begin
          pending.push_back(exp_t'{addr: req.addr, rsp: exp_rsp});
        end
        if (req.op == OP_WRITE && req.addr == DISP_ADDR) begin
          disp_mirror = req.wdata;
          skip        = 3;
        end
      end
      // Counter runs every cycle and restarts from a write
      if (req_valid && req_ready && req.op == OP_WRITE && req.addr == CNT_ADDR) begin
        cnt_model = '0;
      end else begin
        cnt_model++;
      end
    end
    idle = (pending.size() == 0);
  end

endmodule

// ==== test/tb_top.sv ====
module tb_top
  import soc_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int RAS_DEPTH = 8;

  typedef struct packed {
    logic [7:0]  test;
    logic [7:0]  op;
    logic [31:0] addr;
    logic [31:0] data;
  } vec_t;

  logic        clk;
  logic        arst_n;
  logic        req_valid;
  logic        req_ready;
  bus_req_t    req;
  logic        rsp_valid;
  logic        rsp_ready;
  bus_rsp_t    rsp;
  ras_evt_t    ras_evt;
  logic [7:0]  an;
  logic [6:0]  seg;
  bus_rsp_t    exp_rsp;
  logic        exp_cnt;
  int          test_num;
  logic        idle;
  int          err_count;
  int          tests_run;
  int          tests_failed;
  int          bad_vectors;
  logic        loaded;
  logic        vecs_loaded;
  integer      seed = 32'hfeee;
  vec_t        vecs [$];
  logic [31:0] model_q [$];
  logic [15:0] model_mis;

  soc_top #(
    .RAM_WORDS(256),
    .RAS_DEPTH(RAS_DEPTH),
    .SCAN_DIV (4)
  ) soc_top_i (
    .clk      (clk),
    .arst_n   (arst_n),
    .req_valid(req_valid),
    .req_ready(req_ready),
    .req      (req),
    .rsp_valid(rsp_valid),
    .rsp_ready(rsp_ready),
    .rsp      (rsp),
    .ras_evt  (ras_evt),
    .an       (an),
    .seg      (seg)
  );

  tb_checker resp_check_i (
    .clk         (clk),
    .arst_n      (arst_n),
    .req_valid   (req_valid),
    .req_ready   (req_ready),
    .req         (req),
    .rsp_valid   (rsp_valid),
    .rsp_ready   (rsp_ready),
    .rsp         (rsp),
    .an          (an),
    .seg         (seg),
    .exp_rsp     (exp_rsp),
    .exp_cnt     (exp_cnt),
    .test_num    (test_num),
    .idle        (idle),
    .err_count   (err_count),
    .tests_run   (tests_run),
    .tests_failed(tests_failed)
  );

  always #10 clk = ~clk;

  // Random back-pressure on responses
  always @(negedge clk) begin
    if (arst_n) rsp_ready = (($random(seed) & 3) != 0);
  end

  function automatic bus_rsp_t model_status();
    ras_status_t st;
    st.mismatch_count = model_mis;
    st.occupancy      = 8'(model_q.size());
    st.reserved       = '0;
    st.full           = (model_q.size() == RAS_DEPTH);
    st.empty          = (model_q.size() == 0);
    return bus_rsp_t'{err: 1'b0, rdata: st};
  endfunction

  task automatic load_vectors(output logic ok);
    int          fd;
    int          n;
    string       line;
    logic [7:0]  t;
    logic [7:0]  o;
    logic [31:0] a;
    logic [31:0] d;
    ok = 1'b0;
    fd = $fopen("test/soc_vectors.txt", "r");
    if (fd == 0) begin
      $display("Cannot open the vector file test/soc_vectors.txt");
    end else begin
      while (!$feof(fd)) begin
        n = $fgets(line, fd);
        if (n > 0 && line[0] != "#") begin
          if ($sscanf(line, "%h %h %h %h", t, o, a, d) == 4) vecs.push_back({t, o, a, d});
        end
      end
      $fclose(fd);
      ok = (vecs.size() > 0);
      if (!ok) $display("The vector file holds no vectors");
    end
  endtask

  task automatic wait_idle();
    while (!idle) @(negedge clk);
  endtask

  task automatic bus_access(input bus_op_e op, input logic [31:0] addr,
                            input logic [31:0] wdata, input bus_rsp_t exp, input logic cnt);
    req_valid = 1'b1;
    req       = bus_req_t'{op: op, addr: addr, wdata: wdata};
    exp_rsp   = exp;
    exp_cnt   = cnt;
    do begin
      @(posedge clk);
    end while (!req_ready);
    @(negedge clk);
    req_valid = 1'b0;
  endtask

  // Calls push ascending targets, returns expect them in reverse
  task automatic stack_events(input ras_op_e op, input logic [31:0] base, input int count);
    logic [31:0] target;
    logic        miss;
    for (int i = 0; i < count; i++) begin
      target  = (op == RAS_CALL) ? base + 32'(4 * i) : base + 32'(4 * (count - 1 - i));
      ras_evt = ras_evt_t'{op: op, addr: target};
      if (op == RAS_CALL) begin
        model_q.push_back(target);
        if (model_q.size() > RAS_DEPTH) void'(model_q.pop_front());
      end else begin
        if (model_q.size() == 0) miss = 1'b1;
        else miss = (model_q.pop_back() != target);
        if (miss && model_mis != 16'hFFFF) model_mis++;
      end
      @(negedge clk);
    end
    ras_evt = ras_evt_t'{op: RAS_NONE, addr: '0};
  endtask

  task automatic run_vectors();
    vec_t v;
    foreach (vecs[i]) begin
      v = vecs[i];
      if (int'(v.test) != test_num) begin
        wait_idle();
        test_num = v.test;
      end
      case (v.op)
        8'h0: begin
          bus_access(OP_WRITE, v.addr, v.data, '0, 1'b0);
          if (v.addr == RAS_STAT_ADDR) model_mis = '0;
        end
        8'h1: bus_access(OP_READ, v.addr, '0, bus_rsp_t'{1'b0, v.data}, 1'b0);
        8'h2: bus_access(OP_WRITE, v.addr, v.data, bus_rsp_t'{1'b1, 32'd0}, 1'b0);
        8'h3: bus_access(OP_READ, v.addr, '0, bus_rsp_t'{1'b1, 32'd0}, 1'b0);
        8'h4: stack_events(RAS_CALL, v.addr, int'(v.data));
        8'h5: stack_events(RAS_RET, v.addr, int'(v.data));
        8'h6: bus_access(OP_READ, RAS_STAT_ADDR, '0, model_status(), 1'b0);
        8'h7: bus_access(OP_READ, RAS_TOP_ADDR, '0,
                         bus_rsp_t'{1'b0, (model_q.size() > 0) ? model_q[$] : 32'd0}, 1'b0);
        8'h8: bus_access(OP_READ, CNT_ADDR, '0, '0, 1'b1);
        8'h9: repeat (int'(v.data)) @(negedge clk);
        default: begin
          $display("Vector %0d has an unknown operation %0h", i, v.op);
          bad_vectors++;
        end
      endcase
    end
  endtask

  task automatic finish_run();
    int errors;
    wait_idle();
    test_num = 0;
    repeat (2) @(negedge clk);
    errors = err_count + bad_vectors;
    $display("Tests run: %0d, tests failed: %0d, errors: %0d", tests_run, tests_failed, errors);
    if (loaded && errors == 0 && tests_failed == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  endtask

  initial begin
    clk         = 1'b0;
    arst_n      = 1'b0;
    req_valid   = 1'b0;
    req         = '0;
    rsp_ready   = 1'b0;
    ras_evt     = ras_evt_t'{op: RAS_NONE, addr: '0};
    exp_rsp     = '0;
    exp_cnt     = 1'b0;
    test_num    = 0;
    bad_vectors = 0;
    model_mis   = '0;
    vecs_loaded = 1'b0;
    load_vectors(loaded);
    vecs_loaded = 1'b1;
    repeat (5) @(negedge clk);
    arst_n = 1'b1;
    if (loaded) run_vectors();
    finish_run();
  end

  // Watchdog sized from the vector count
  initial begin
    longint limit_ns;
    wait (vecs_loaded === 1'b1);
    limit_ns = longint'(vecs.size()) * 40 * 20 + 2000;
    #(limit_ns);
    $display("The run timed out after %0d ns without finishing", limit_ns);
    $display("Some tests failed");
    $finish;
  end

endmodule

// ==== project.f ====
design/soc_pkg.sv
design/mem_controller.sv
design/return_stack.sv
design/seg_display.sv
design/soc_top.sv
test/tb_checker.sv
test/tb_top.sv

// ==== run.sh ====
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --timescale 1ns/100ps \
  -f project.f --top-module tb_top -o sim_tb
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^All tests passed$" sim.log; then
  exit 0
fi
echo "Pass message not found in sim.log"
exit 1

// ==== test/soc_vectors.txt ====
# Columns: test op addr data, all hex; data is write data, expected data or a count
# op: 0 wr, 1 rd, 2 wr err, 3 rd err, 4 calls, 5 rets, 6 stat, 7 top, 8 cnt, 9 watch
1 0 00000000 deadbeef
1 0 000003fc a5a5a5a5
1 0 00000010 12345678
1 1 00000000 deadbeef
1 1 000003fc a5a5a5a5
1 1 00000010 12345678
2 2 00000400 11111111
2 3 00001010 00000000
3 4 00000100 00000003
3 6 00000000 00000000
3 7 00000000 00000000
3 5 00000100 00000003
3 6 00000000 00000000
4 5 00000500 00000001
4 4 00000200 00000002
4 5 00000999 00000001
4 4 00000300 00000009
4 5 00000300 00000009
4 6 00000000 00000000
4 0 00001008 00000000
4 6 00000000 00000000
5 0 00001004 00000000
5 8 00001004 00000000
5 8 00001004 00000000
6 0 00001000 89abcdef
6 1 00001000 89abcdef
6 9 00000000 00000040
